//--- common/fetch_macros.svh
// Fetch stage macros for widths, reset PC and the decode bubble word
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Halfword PC covers byte address bits 18:1
`define FETCH_PC_W 18

// Instruction word width
`define FETCH_XLEN 32

// PC loaded on reset
`define FETCH_RESET_PC 0

// addi x0, x0, 0 sent to decode on reset, flush or memory wait.
// An all-zero word would decode as an illegal instruction
`define FETCH_BUBBLE_INSN 32'h00000013

`endif

//--- common/fetch_isa_pkg.sv
// Fetch ISA package with instruction word, register index and opcode types
`include "fetch_macros.svh"

package fetch_isa_pkg;

   typedef logic [`FETCH_XLEN-1:0] insn_t;
   typedef logic [4:0]             reg_idx_t;
   typedef logic [2:0]             creg_t;    // Compressed register, x8..x15

   // Major opcodes produced by the expander or checked by the predictor
   typedef enum logic [6:0] {
      OP     = 7'b0110011,
      OP_IMM = 7'b0010011,
      LUI    = 7'b0110111,
      LOAD   = 7'b0000011,
      STORE  = 7'b0100011,
      BRANCH = 7'b1100011,
      JAL    = 7'b1101111,
      JALR   = 7'b1100111,
      SYSTEM = 7'b1110011
   } opcode_e;

   // Registers with a fixed role in compressed forms
   localparam reg_idx_t REG_ZERO = 5'd0;
   localparam reg_idx_t REG_RA   = 5'd1;
   localparam reg_idx_t REG_SP   = 5'd2;

   // rd'/rs1'/rs2' select from x8 upwards
   function automatic reg_idx_t creg_to_idx(creg_t r);
      return {2'b01, r};
   endfunction

endpackage

//--- common/fetch_pipe_pkg.sv
// Fetch pipeline package with PC, prediction, redirect and decode bundle types
`include "fetch_macros.svh"

package fetch_pipe_pkg;
   import fetch_isa_pkg::*;

   typedef logic [`FETCH_PC_W-1:0] pc_t;    // Halfword address

   typedef struct packed {
      insn_t insn;            // Always a 32-bit encoding
      logic  is_compressed;   // Source was a 16-bit word
   } fetch_word_t;

   typedef struct packed {
      logic taken;
      pc_t  target;
   } prediction_t;

   typedef struct packed {
      logic valid;
      pc_t  target;
   } redirect_t;

   // 68 bits towards decode
   typedef struct packed {
      insn_t insn;
      pc_t   pc;
      pc_t   pc_seq;
   } dec_bundle_t;

   typedef enum logic [1:0] {SRC_SEQ, SRC_PRED, SRC_REDIRECT} pc_src_e;

endpackage

//--- rvc/rvc_expander.sv
// RVC expander, turns 16-bit compressed words into their 32-bit encodings
`timescale 1ns/1ps

module rvc_expander import fetch_isa_pkg::*, fetch_pipe_pkg::*; (
   input  insn_t       raw_i,
   output fetch_word_t word_o
);

   logic [15:0] c;
   logic        is_c;
   reg_idx_t    rd;
   reg_idx_t    rs2;
   reg_idx_t    rdp;       // rd'/rs2' from bits 4:2
   reg_idx_t    rs1p;      // rs1'/rd' from bits 9:7
   reg_idx_t    link;
   insn_t       exp_insn;

   assign c    = raw_i[15:0];
   assign is_c = (raw_i[1:0] != 2'b11);
   assign rd   = c[11:7];
   assign rs2  = c[6:2];
   assign rdp  = creg_to_idx(c[4:2]);
   assign rs1p = creg_to_idx(c[9:7]);
   assign link = c[15] ? REG_ZERO : REG_RA;   // C.J vs C.JAL

   always_comb begin
      exp_insn = '0;   // Illegal unless a pattern below matches
      casez ({c[15:13], c[1:0]})
         5'b000_00: begin   // C.ADDI4SPN
            if (c[12:5] != 8'd0) begin
               exp_insn = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00,
                           REG_SP, 3'b000, rdp, OP_IMM};
            end
         end
         5'b010_00: exp_insn = {5'd0, c[5], c[12:10], c[6], 2'b00, rs1p, 3'b010, rdp, LOAD};
         5'b110_00: exp_insn = {5'd0, c[5], c[12], rdp, rs1p, 3'b010,
                                c[11:10], c[6], 2'b00, STORE};   // C.SW
         5'b000_01: exp_insn = {{6{c[12]}}, c[12], c[6:2], rd, 3'b000, rd, OP_IMM};
         5'b?01_01: begin   // C.JAL and C.J share the offset layout
            exp_insn = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                        {9{c[12]}}, link, JAL};
         end
         5'b010_01: exp_insn = {{6{c[12]}}, c[12], c[6:2], REG_ZERO, 3'b000, rd, OP_IMM};
         5'b011_01: begin
            if ({c[12], c[6:2]} != 6'd0) begin
               if (rd == REG_SP) begin   // C.ADDI16SP
                  exp_insn = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000,
                              REG_SP, 3'b000, REG_SP, OP_IMM};
               end else begin
                  exp_insn = {{15{c[12]}}, c[6:2], rd, LUI};
               end
            end
         end
         5'b100_01: begin
            case (c[11:10])
               2'b00: begin   // C.SRLI, shamt[5] reserved on RV32
                  if (!c[12]) exp_insn = {7'b0000000, c[6:2], rs1p, 3'b101, rs1p, OP_IMM};
               end
               2'b01: begin   // C.SRAI
                  if (!c[12]) exp_insn = {7'b0100000, c[6:2], rs1p, 3'b101, rs1p, OP_IMM};
               end
               2'b10: exp_insn = {{6{c[12]}}, c[12], c[6:2], rs1p, 3'b111, rs1p, OP_IMM};
               default: begin
                  if (!c[12]) begin   // Register ALU ops, c[12] set is RV64 only
                     case (c[6:5])
                        2'b00:   exp_insn = {7'b0100000, rdp, rs1p, 3'b000, rs1p, OP};
                        2'b01:   exp_insn = {7'b0000000, rdp, rs1p, 3'b100, rs1p, OP};
                        2'b10:   exp_insn = {7'b0000000, rdp, rs1p, 3'b110, rs1p, OP};
                        default: exp_insn = {7'b0000000, rdp, rs1p, 3'b111, rs1p, OP};
                     endcase
                  end
               end
            endcase
         end
         5'b11?_01: begin   // C.BEQZ / C.BNEZ, funct3 low bit from c[13]
            exp_insn = {{4{c[12]}}, c[6:5], c[2], REG_ZERO, rs1p, 2'b00, c[13],
                        c[11:10], c[4:3], c[12], BRANCH};
         end
         5'b000_10: begin   // C.SLLI
            if (!c[12]) exp_insn = {7'b0000000, c[6:2], rd, 3'b001, rd, OP_IMM};
         end
         5'b010_10: begin   // C.LWSP, rd = x0 reserved
            if (rd != REG_ZERO) begin
               exp_insn = {4'd0, c[3:2], c[12], c[6:4], 2'b00, REG_SP, 3'b010, rd, LOAD};
            end
         end
         5'b100_10: begin
            if (!c[12]) begin
               if (rs2 == REG_ZERO) begin
                  if (rd != REG_ZERO) exp_insn = {12'd0, rd, 3'b000, REG_ZERO, JALR};  // C.JR
               end else begin
                  exp_insn = {7'd0, rs2, REG_ZERO, 3'b000, rd, OP};   // C.MV
               end
            end else if (rs2 == REG_ZERO) begin
               if (rd == REG_ZERO) begin
                  exp_insn = {12'd1, REG_ZERO, 3'b000, REG_ZERO, SYSTEM};   // C.EBREAK
               end else begin
                  exp_insn = {12'd0, rd, 3'b000, REG_RA, JALR};   // C.JALR
               end
            end else begin
               exp_insn = {7'd0, rs2, rd, 3'b000, rd, OP};   // C.ADD
            end
         end
         5'b110_10: exp_insn = {4'd0, c[8:7], c[12], rs2, REG_SP, 3'b010,
                                c[11:9], 2'b00, STORE};   // C.SWSP
         default: exp_insn = '0;
      endcase
   end

   assign word_o.insn          = is_c ? exp_insn : raw_i;
   assign word_o.is_compressed = is_c;

   // Every expansion must land on a 32-bit opcode or on the illegal word
   always_comb begin
      if (word_o.is_compressed) begin
         assert (word_o.insn[1:0] == 2'b11 || word_o.insn == '0)
            else $error("rvc_expander: bad expansion %h -> %h", c, word_o.insn);
      end
   end

endmodule

//--- logic/branch_predict.sv
// Static branch predictor, jal and backward branches taken
`timescale 1ns/1ps

module branch_predict import fetch_isa_pkg::*, fetch_pipe_pkg::*; (
   input  logic        clk_i,
   input  fetch_word_t word_i,
   input  pc_t         pc_i,
   output prediction_t pred_o
);

   opcode_e opcode;
   pc_t     j_off;    // Halfword offsets
   pc_t     b_off;
   pc_t     off;
   logic    taken;

   assign opcode = opcode_e'(word_i.insn[6:0]);

   // J immediate truncated to the PC width, wraps with the PC
   assign j_off = {word_i.insn[18:12], word_i.insn[20], word_i.insn[30:21]};

   // B immediate sign extended
   assign b_off = {{7{word_i.insn[31]}}, word_i.insn[7], word_i.insn[30:25],
                   word_i.insn[11:8]};

   always_comb begin
      taken = 1'b0;
      off   = b_off;
      case (opcode)
         JAL: begin
            taken = 1'b1;
            off   = j_off;
         end
         BRANCH: taken = b_off[`FETCH_PC_W-1];   // Backward loops only
         default: taken = 1'b0;                  // jalr left to execute
      endcase
   end

   assign pred_o.taken  = taken;
   assign pred_o.target = pc_i + off;

   a_taken_is_ctrl: assert property (@(posedge clk_i)
      pred_o.taken |-> (opcode == JAL || opcode == BRANCH))
      else $error("branch_predict: taken on opcode %b", word_i.insn[6:0]);

endmodule

//--- logic/fetch_ctrl.sv
// Fetch control, owns the PC, picks the next PC and registers the decode bundle
`timescale 1ns/1ps

`include "fetch_macros.svh"

module fetch_ctrl import fetch_pipe_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        stall_i,
   input  logic        flush_i,
   input  logic        mem_wait_i,
   input  fetch_word_t word_i,
   input  prediction_t pred_i,
   input  redirect_t   redirect_i,
   output pc_t         pc_o,
   output dec_bundle_t dec_o
);

   pc_t     pc_q;
   pc_t     pc_seq;
   pc_t     pc_next;
   pc_src_e pc_src;

   // Step in halfwords
   assign pc_seq = word_i.is_compressed ? pc_q + pc_t'(1) : pc_q + pc_t'(2);

   // Execute beats the prediction, prediction beats sequential
   always_comb begin
      if (redirect_i.valid) begin
         pc_src = SRC_REDIRECT;
      end else if (pred_i.taken) begin
         pc_src = SRC_PRED;
      end else begin
         pc_src = SRC_SEQ;
      end
   end

   always_comb begin
      case (pc_src)
         SRC_REDIRECT: pc_next = redirect_i.target;
         SRC_PRED:     pc_next = pred_i.target;
         default:      pc_next = pc_seq;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pc_q         <= pc_t'(`FETCH_RESET_PC);
         dec_o.insn   <= `FETCH_BUBBLE_INSN;
         dec_o.pc     <= '0;
         dec_o.pc_seq <= '0;
      end else if (!stall_i) begin
         if (mem_wait_i) begin
            // Data not valid, only a redirect may move the PC
            if (redirect_i.valid) begin
               pc_q <= redirect_i.target;
            end
            dec_o.insn <= `FETCH_BUBBLE_INSN;
         end else begin
            pc_q       <= pc_next;
            dec_o.insn <= flush_i ? `FETCH_BUBBLE_INSN : word_i.insn;
         end
         dec_o.pc     <= pc_q;
         dec_o.pc_seq <= pc_seq;
      end
   end

   assign pc_o = pc_q;

   a_redirect_loads: assert property (@(posedge clk_i) disable iff (rst_i)
      (!stall_i && redirect_i.valid) |=> (pc_o == $past(redirect_i.target)))
      else $error("fetch_ctrl: redirect target not on pc_o");

   // Decode back-pressure must not lose or change the held bundle
   a_stall_holds: assert property (@(posedge clk_i) disable iff (rst_i)
      stall_i |=> $stable(dec_o))
      else $error("fetch_ctrl: dec_o changed across a stall");

endmodule

//--- logic/fetch_top.sv
// Instruction fetch stage top, connects expander, static predictor and control
`timescale 1ns/1ps

module fetch_top import fetch_isa_pkg::*, fetch_pipe_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        stall_i,
   input  logic        flush_i,
   input  logic        mem_wait_i,
   input  insn_t       mem_data_i,
   input  redirect_t   redirect_i,
   output pc_t         mem_addr_o,
   output dec_bundle_t dec_o
);

   fetch_word_t word;   // Expanded memory word
   prediction_t pred;
   pc_t         pc;

   rvc_expander u_rvc_expander (
      .raw_i  (mem_data_i),
      .word_o (word)
   );

   branch_predict u_branch_predict (
      .clk_i  (clk_i),
      .word_i (word),
      .pc_i   (pc),
      .pred_o (pred)
   );

   fetch_ctrl u_fetch_ctrl (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .stall_i    (stall_i),
      .flush_i    (flush_i),
      .mem_wait_i (mem_wait_i),
      .word_i     (word),
      .pred_i     (pred),
      .redirect_i (redirect_i),
      .pc_o       (pc),
      .dec_o      (dec_o)
   );

   assign mem_addr_o = pc;   // Memory sees the live PC

endmodule

//--- sim/tb_clk_gen.sv
// Testbench clock and reset source, 8 ns period with a 2-cycle reset
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int PERIOD_NS = 8
) (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   initial begin
      rst_o = 1'b1;
      repeat (2) @(posedge clk_o);
      rst_o <= 1'b0;   // Released just after the second edge
   end

endmodule

//--- sim/tb_fetch.sv
// Fetch stage testbench with a ROM model, stimulus table and expected-trace model
`timescale 1ns/1ps

`include "fetch_macros.svh"

module tb_fetch import fetch_isa_pkg::*, fetch_pipe_pkg::*; ();

   localparam int NUM_ROWS  = 64;
   localparam int MAX_EXTRA = 32;   // Cap on inserted wait cycles
   localparam int WDOG_NS   = (NUM_ROWS * 2 + 50) * 8;

   typedef struct packed {
      logic      stall;
      logic      flush;
      logic      mwait;
      redirect_t redir;
   } stim_t;

   logic        clk;
   logic        rst;
   logic        stall;
   logic        flush;
   logic        mem_wait;
   insn_t       mem_data;
   redirect_t   redir;
   pc_t         mem_addr;
   dec_bundle_t dec;

   logic [15:0] rom [256];          // Halfword program memory
   logic        known [256];        // Instruction starts here
   insn_t       exp_tbl [256];      // Reference 32-bit form
   logic        isc_tbl [256];
   logic        tk_tbl [256];       // Statically predicted taken
   int          off_tbl [256];      // Target offset in halfwords
   stim_t       tbl [NUM_ROWS];

   pc_t         m_pc;
   dec_bundle_t m_dec;
   logic        m_wait;             // Last advancing edge was a wait
   logic [49:0] trace_q [$];        // {pc, insn} of real instructions
   int          cmp_idx;
   logic [7:0]  lo_idx;
   logic [7:0]  hi_idx;

   tb_clk_gen #(.PERIOD_NS(8)) u_clk_gen (
      .clk_o (clk),
      .rst_o (rst)
   );

   fetch_top uut (
      .clk_i      (clk),
      .rst_i      (rst),
      .stall_i    (stall),
      .flush_i    (flush),
      .mem_wait_i (mem_wait),
      .mem_data_i (mem_data),
      .redirect_i (redir),
      .mem_addr_o (mem_addr),
      .dec_o      (dec)
   );

   // Same-cycle read, unaligned allowed
   assign lo_idx   = mem_addr[7:0];
   assign hi_idx   = lo_idx + 8'd1;
   assign mem_data = {rom[hi_idx], rom[lo_idx]};

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic check_eq(input logic [67:0] got, input logic [67:0] exp, input string what);
      if (got !== exp) begin
         $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("TB FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic add_insn(input int a, input insn_t raw, input insn_t exp,
                           input logic taken, input int off);
      rom[a]     = raw[15:0];
      known[a]   = 1'b1;
      exp_tbl[a] = exp;
      isc_tbl[a] = (raw[1:0] != 2'b11);
      tk_tbl[a]  = taken;
      off_tbl[a] = off;
      if (raw[1:0] == 2'b11) rom[a+1] = raw[31:16];
   endtask

   task automatic load_program();
      for (int i = 0; i < 256; i++) begin
         rom[i]   = {i[7:0], ~i[7:0]};   // Filler, never fetched
         known[i] = 1'b0;
      end
      add_insn(0,  32'h0100006F, 32'h0100006F, 1'b1, 8);    // jal x0, +16
      add_insn(2,  32'hFE000EE3, 32'hFE000EE3, 1'b1, -2);   // beq x0,x0,-4
      add_insn(4,  32'h0800, 32'h01010413, 1'b0, 0);        // c.addi4spn
      add_insn(5,  32'h4044, 32'h00442483, 1'b0, 0);        // c.lw
      add_insn(6,  32'hC404, 32'h00942423, 1'b0, 0);        // c.sw
      add_insn(7,  32'h1575, 32'hFFD50513, 1'b0, 0);        // c.addi
      add_insn(8,  32'h459D, 32'h00700593, 1'b0, 0);        // c.li
      add_insn(9,  32'h667D, 32'h0001F637, 1'b0, 0);        // c.lui
      add_insn(10, 32'h713D, 32'hFE010113, 1'b0, 0);        // c.addi16sp
      add_insn(11, 32'h800D, 32'h00345413, 1'b0, 0);        // c.srli
      add_insn(12, 32'h8495, 32'h4054D493, 1'b0, 0);        // c.srai
      add_insn(13, 32'h997D, 32'hFFF57513, 1'b0, 0);        // c.andi
      add_insn(14, 32'h8C05, 32'h40940433, 1'b0, 0);        // c.sub
      add_insn(15, 32'h8CA9, 32'h00A4C4B3, 1'b0, 0);        // c.xor
      add_insn(16, 32'h8D4D, 32'h00B56533, 1'b0, 0);        // c.or
      add_insn(17, 32'h8DF1, 32'h00C5F5B3, 1'b0, 0);        // c.and
      add_insn(18, 32'h00128293, 32'h00128293, 1'b0, 0);    // addi x5,x5,1
      add_insn(20, 32'hC011, 32'h00040263, 1'b0, 0);        // c.beqz forward
      add_insn(21, 32'h068A, 32'h00269693, 1'b0, 0);        // c.slli
      add_insn(22, 32'h4732, 32'h00C12703, 1'b0, 0);        // c.lwsp
      add_insn(23, 32'h87BA, 32'h00E007B3, 1'b0, 0);        // c.mv
      add_insn(24, 32'h97B6, 32'h00D787B3, 1'b0, 0);        // c.add
      add_insn(25, 32'h8082, 32'h00008067, 1'b0, 0);        // c.jr
      add_insn(26, 32'h9282, 32'h000280E7, 1'b0, 0);        // c.jalr
      add_insn(27, 32'hC436, 32'h00D12423, 1'b0, 0);        // c.swsp
      add_insn(28, 32'h00209463, 32'h00209463, 1'b0, 0);    // bne forward
      add_insn(30, 32'h2011, 32'h004000EF, 1'b1, 2);        // c.jal +4
      add_insn(31, 32'h9002, 32'h00100073, 1'b0, 0);        // c.ebreak
      add_insn(32, 32'hA011, 32'h0040006F, 1'b1, 2);        // c.j +4
      add_insn(33, 32'h0001, 32'h00000013, 1'b0, 0);        // c.nop
      add_insn(34, 32'hF071, 32'hFC0412E3, 1'b1, -30);      // c.bnez back to 4
   endtask

   task automatic set_row(input int r, input logic s, input logic f, input logic w,
                          input logic v, input int tgt);
      tbl[r].stall        = s;
      tbl[r].flush        = f;
      tbl[r].mwait        = w;
      tbl[r].redir.valid  = v;
      tbl[r].redir.target = pc_t'(tgt);
   endtask

   task automatic build_table();
      for (int r = 0; r < NUM_ROWS; r++) tbl[r] = '0;
      set_row(0,  0, 0, 0, 1, 0);    // Common start point for both passes
      set_row(1,  0, 0, 0, 1, 20);   // Beats the jal at 0
      set_row(5,  1, 0, 0, 0, 0);
      set_row(6,  1, 0, 0, 0, 0);
      set_row(9,  0, 0, 1, 0, 0);
      set_row(10, 0, 0, 1, 1, 31);   // Redirect during a memory wait
      set_row(14, 0, 1, 0, 0, 0);
      set_row(20, 0, 0, 0, 1, 2);
      set_row(27, 0, 1, 0, 1, 12);
      set_row(33, 1, 0, 0, 1, 20);   // Stall wins over the redirect
      set_row(45, 0, 0, 1, 0, 0);
      set_row(46, 0, 0, 1, 0, 0);
      set_row(49, 0, 0, 0, 1, 33);   // Overrides the taken c.bnez
      set_row(50, 0, 0, 0, 1, 4);
      set_row(55, 0, 1, 0, 0, 0);
      set_row(58, 1, 0, 1, 0, 0);
   endtask

   // Expected state after one edge with these inputs
   task automatic step_model(input stim_t s);
      pc_t seq;
      pc_t tgt;
      int  a;
      if (s.stall) return;
      a = int'(m_pc);
      if (a >= 256 || !known[a]) begin
         $display("Model PC %0d is not the start of a program instruction", a);
         $display("TB FAILED");
         $fatal(1, "PC outside program");
      end
      seq          = m_pc + (isc_tbl[a] ? pc_t'(1) : pc_t'(2));
      tgt          = m_pc + pc_t'(off_tbl[a]);
      m_dec.pc     = m_pc;
      m_dec.pc_seq = seq;
      m_wait       = s.mwait;
      if (s.mwait) begin
         m_dec.insn = `FETCH_BUBBLE_INSN;
         if (s.redir.valid) m_pc = s.redir.target;
      end else begin
         m_dec.insn = s.flush ? `FETCH_BUBBLE_INSN : exp_tbl[a];
         if (s.redir.valid) m_pc = s.redir.target;
         else if (tk_tbl[a]) m_pc = tgt;
         else m_pc = seq;
      end
   endtask

   task automatic run_row(input stim_t s, input int pass, input logic rec);
      stall    = s.stall;
      flush    = s.flush;
      mem_wait = s.mwait;
      redir    = s.redir;
      step_model(s);
      @(posedge clk);
      #1;
      check_eq(68'(mem_addr), 68'(m_pc), "mem_addr_o");
      check_eq(68'(dec.insn), 68'(m_dec.insn), "dec_o.insn");
      if (!m_wait) begin   // Bundle address fields only matter with real data
         check_eq(68'(dec.pc), 68'(m_dec.pc), "dec_o.pc");
         check_eq(68'(dec.pc_seq), 68'(m_dec.pc_seq), "dec_o.pc_seq");
      end
      if (rec && !s.stall && !s.mwait && !s.flush) begin
         if (pass == 0) begin
            trace_q.push_back({dec.pc, dec.insn});
         end else begin
            check_eq(68'({dec.pc, dec.insn}), 68'(trace_q[cmp_idx]), "replayed trace");
            cmp_idx++;
         end
      end
   endtask

   initial begin
      #(WDOG_NS);
      $display("Timeout, the run did not finish within %0d ns", WDOG_NS);
      $display("TB FAILED");
      $fatal(1, "watchdog");
   end

   initial begin
      logic [31:0] rng;
      int          extra;
      int          n;
      stim_t       wait_row;
      stall    = 1'b1;   // Hold the first edge after reset
      flush    = 1'b0;
      mem_wait = 1'b0;
      redir    = '0;
      load_program();
      build_table();
      m_pc    = pc_t'(`FETCH_RESET_PC);
      m_dec   = '0;
      m_dec.insn = `FETCH_BUBBLE_INSN;
      m_wait  = 1'b0;
      cmp_idx = 0;
      @(negedge rst);
      @(posedge clk);
      #1;
      check_eq(68'(mem_addr), 68'(`FETCH_RESET_PC), "mem_addr_o after reset");
      check_eq(68'(dec), 68'(m_dec), "dec_o after reset");

      for (int r = 0; r < NUM_ROWS; r++) run_row(tbl[r], 0, r > 0);

      // Second pass with random memory waits in between
      rng      = 32'hc5a9a784;
      extra    = 0;
      wait_row = '0;
      wait_row.mwait = 1'b1;
      for (int r = 0; r < NUM_ROWS; r++) begin
         rng = xorshift32(rng);
         if (rng[1:0] == 2'b00 && extra < MAX_EXTRA) begin
            n = 1 + int'(rng[2]);
            repeat (n) run_row(wait_row, 1, 1'b0);
            extra += n;
         end
         run_row(tbl[r], 1, r > 0);
      end

      $display("TB PASSED");
      $finish;
   end

endmodule

//--- flist.f
+incdir+common
common/fetch_isa_pkg.sv
common/fetch_pipe_pkg.sv
rvc/rvc_expander.sv
logic/branch_predict.sv
logic/fetch_ctrl.sv
logic/fetch_top.sv
sim/tb_clk_gen.sv
sim/tb_fetch.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_fetch -f flist.f

# A failing run still leaves its log for the search below
./obj_dir/Vtb_fetch > sim.log 2>&1 || true
cat sim.log

if grep -qx "TB PASSED" sim.log; then
   exit 0
else
   exit 1
fi
